//--- source/ecc_code_pkg.sv
package ecc_code_pkg;

    localparam int unsigned data_w  = 104;
    localparam int unsigned check_w = 8;
    localparam int unsigned pos_w   = 7;

    typedef logic [data_w-1:0]  data_t;
    typedef logic [check_w-1:0] check_t;

    // kind of error seen by the decoder for one codeword.
    typedef enum logic [1:0] {
        err_none          = 2'd0,
        err_corrected     = 2'd1,
        err_uncorrectable = 2'd2
    } err_kind_e;

    // data bit idx sits at the idx-th Hamming position, counting from 3,
    // that is not a power of two. The powers of two are left to the check
    // bits themselves.
    // the top bit makes the column weight odd, which keeps every column
    // apart from every double-error syndrome.
    function automatic check_t check_column(input int unsigned idx);
        int unsigned      n;
        logic [pos_w-1:0] pos;
        n = 0;
        pos = '0;
        for (int unsigned v = 3; v < 2 ** pos_w; v++) begin
            if ((v & (v - 1)) != 0) begin
                if (n == idx) begin
                    pos = pos_w'(v);
                end
                n++;
            end
        end
        return {~^pos, pos};
    endfunction

endpackage

//--- source/ecc_bus_pkg.sv
package ecc_bus_pkg;

    // received or stored codeword, data in the upper bits.
    typedef struct packed {
        ecc_code_pkg::data_t  data;
        ecc_code_pkg::check_t check;
    } codeword_t;

    // corrected word together with what the decoder found.
    typedef struct packed {
        ecc_code_pkg::data_t     data;
        ecc_code_pkg::err_kind_e kind;
    } dec_result_t;

endpackage

//--- source/ecc_encoder.sv
`timescale 1ns/1ps

module ecc_encoder (
    input  ecc_code_pkg::data_t       data,
    output wire ecc_code_pkg::check_t check
);

    // gathers, for one check bit, every data bit whose column has it set.
    function automatic ecc_code_pkg::data_t row_mask(input int unsigned row);
        ecc_code_pkg::data_t  mask;
        ecc_code_pkg::check_t col;
        mask = '0;
        for (int unsigned i = 0; i < ecc_code_pkg::data_w; i++) begin
            col = ecc_code_pkg::check_column(i);
            mask[i] = col[row];
        end
        return mask;
    endfunction

    // each check bit is the parity of the data bits under its row mask.
    for (genvar j = 0; j < ecc_code_pkg::check_w; j++) begin : g_row
        localparam ecc_code_pkg::data_t mask = row_mask(j);

        assign check[j] = ^(data & mask);
    end

endmodule

//--- source/ecc_syndrome_decoder.sv
`timescale 1ns/1ps

module ecc_syndrome_decoder (
    input  ecc_code_pkg::check_t      rx_check,
    input  ecc_code_pkg::check_t      calc_check,
    output wire ecc_code_pkg::data_t  flip_mask,
    output ecc_code_pkg::err_kind_e   err_kind
);

    ecc_code_pkg::check_t syndrome;
    logic                 data_hit;
    logic                 check_hit;

    assign syndrome = rx_check ^ calc_check;

    // a syndrome equal to a data column points at the bit to flip.
    for (genvar i = 0; i < ecc_code_pkg::data_w; i++) begin : g_col
        localparam ecc_code_pkg::check_t col = ecc_code_pkg::check_column(i);

        assign flip_mask[i] = (syndrome == col);
    end

    assign data_hit = |flip_mask;

    // a one-hot syndrome is a flipped check bit; the data is already good.
    assign check_hit = ((syndrome & (syndrome - ecc_code_pkg::check_t'(1))) == '0);

    always_comb begin
        if (syndrome == '0) begin
            err_kind = ecc_code_pkg::err_none;
        end else if (data_hit || check_hit) begin
            err_kind = ecc_code_pkg::err_corrected;
        end else begin
            err_kind = ecc_code_pkg::err_uncorrectable;
        end
    end

    // the columns from the package must be distinct, so at most one bit
    // is ever flipped.
    always_comb begin
        assert final ($onehot0(flip_mask))
        else $error("flip mask has more than one bit set");
    end

endmodule

//--- source/ecc_correct_stage.sv
`timescale 1ns/1ps

module ecc_correct_stage (
    input  logic                       clk,
    input  logic                       arst_n,
    input  ecc_code_pkg::data_t        rx_data,
    input  logic                       rx_valid,
    input  logic                       bypass,
    input  ecc_code_pkg::data_t        flip_mask,
    input  ecc_code_pkg::err_kind_e    err_kind,
    output ecc_bus_pkg::dec_result_t   result,
    output logic                       result_valid
);

    ecc_bus_pkg::dec_result_t next_result;

    // bypass hands the word on untouched and hides any error.
    always_comb begin
        if (bypass) begin
            next_result.data = rx_data;
            next_result.kind = ecc_code_pkg::err_none;
        end else begin
            next_result.data = rx_data ^ flip_mask;
            next_result.kind = err_kind;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
            result.data  <= '0;
            result.kind  <= ecc_code_pkg::err_none;
        end else begin
            result_valid <= rx_valid;
            // the result holds between strobes.
            if (rx_valid) begin
                result <= next_result;
            end
        end
    end

    a_bypass_clean: assert property (
        @(posedge clk) disable iff (!arst_n)
        rx_valid && bypass |=> result.kind == ecc_code_pkg::err_none
    ) else $error("bypass word came out with an error kind");

    a_valid_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        !$isunknown(result_valid)
    ) else $error("result_valid is unknown");

endmodule

//--- source/ecc_secded_top.sv
`timescale 1ns/1ps

module ecc_secded_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  ecc_code_pkg::data_t       enc_data,
    output ecc_code_pkg::check_t      enc_check,
    input  ecc_bus_pkg::codeword_t    dec_in,
    input  logic                      dec_valid,
    input  logic                      bypass,
    output ecc_bus_pkg::dec_result_t  dec_out,
    output logic                      out_valid
);

    ecc_code_pkg::check_t    calc_check;
    ecc_code_pkg::data_t     flip_mask;
    ecc_code_pkg::err_kind_e err_kind;

    // write side, purely combinational.
    ecc_encoder enc_path (
        .data  (enc_data),
        .check (enc_check)
    );

    // read side recomputes the check bits of the received data.
    ecc_encoder chk_path (
        .data  (dec_in.data),
        .check (calc_check)
    );

    ecc_syndrome_decoder ecc_syndrome_decoder_i (
        .rx_check   (dec_in.check),
        .calc_check (calc_check),
        .flip_mask  (flip_mask),
        .err_kind   (err_kind)
    );

    ecc_correct_stage ecc_correct_stage_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .rx_data      (dec_in.data),
        .rx_valid     (dec_valid),
        .bypass       (bypass),
        .flip_mask    (flip_mask),
        .err_kind     (err_kind),
        .result       (dec_out),
        .result_valid (out_valid)
    );

endmodule

//--- verification/tb_ecc_model.svh
`ifndef TB_ECC_MODEL_SVH
`define TB_ECC_MODEL_SVH

// galois lfsr state, taps 32, 22, 2 and 1.
logic [31:0] lfsr_state;

// check column of every data bit, filled once at the start of the run.
ecc_code_pkg::check_t columns [ecc_code_pkg::data_w];

function automatic logic next_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return b;
endfunction

function automatic int unsigned random_bits(input int n);
    int unsigned r;
    r = 0;
    for (int i = 0; i < n; i++) begin
        r[i] = next_bit();
    end
    return r;
endfunction

function automatic ecc_code_pkg::data_t random_data();
    ecc_code_pkg::data_t d;
    for (int i = 0; i < ecc_code_pkg::data_w; i++) begin
        d[i] = next_bit();
    end
    return d;
endfunction

// walks the integers from 3 upward and skips the powers of two.
function automatic ecc_code_pkg::check_t column_of(input int idx);
    int         pos;
    int         seen;
    logic [6:0] low;
    logic       top;
    pos = 2;
    seen = -1;
    while (seen < idx) begin
        pos++;
        if ($countones(pos) != 1) begin
            seen++;
        end
    end
    low = pos[6:0];
    top = ($countones(low) % 2) == 0;
    return {top, low};
endfunction

function automatic ecc_code_pkg::check_t ref_encode(input ecc_code_pkg::data_t d);
    ecc_code_pkg::check_t c;
    c = '0;
    for (int i = 0; i < ecc_code_pkg::data_w; i++) begin
        if (d[i]) begin
            c = c ^ columns[i];
        end
    end
    return c;
endfunction

function automatic ecc_bus_pkg::dec_result_t ref_decode(input ecc_bus_pkg::codeword_t cw,
                                                        input logic byp);
    ecc_bus_pkg::dec_result_t res;
    ecc_code_pkg::check_t     syn;
    syn = cw.check ^ ref_encode(cw.data);
    res.data = cw.data;
    res.kind = ecc_code_pkg::err_none;
    if (!byp && syn != '0) begin
        res.kind = ecc_code_pkg::err_uncorrectable;
        if ($onehot(syn)) begin
            res.kind = ecc_code_pkg::err_corrected;
        end
        for (int i = 0; i < ecc_code_pkg::data_w; i++) begin
            if (columns[i] == syn) begin
                res.data[i] = ~res.data[i];
                res.kind = ecc_code_pkg::err_corrected;
            end
        end
    end
    return res;
endfunction

task automatic check_value(input string name, input logic [127:0] expected,
                           input logic [127:0] actual);
    if (expected !== actual) begin
        $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        $display("Done: errors found");
        $fatal(1);
    end
endtask

`endif

//--- verification/tb_ecc_secded_top.sv
`timescale 1ns/1ps

module tb_ecc_secded_top;

    localparam int num_tests    = 6;
    localparam int num_vectors  = 200;
    localparam int reset_cycles = 16;
    localparam int cw_w         = ecc_code_pkg::data_w + ecc_code_pkg::check_w;
    // the margin covers reset, the bypass idle gaps, both sweeps and the drain.
    localparam int timeout_cycles = num_tests * num_vectors + 800;

    logic                     clk;
    logic                     arst_n;
    ecc_code_pkg::data_t      enc_data;
    ecc_code_pkg::check_t     enc_check;
    ecc_bus_pkg::codeword_t   dec_in;
    logic                     dec_valid;
    logic                     bypass;
    ecc_bus_pkg::dec_result_t dec_out;
    logic                     out_valid;

    int cycles;
    int results_seen;

    // words in flight, with the name of their test and their launch cycle.
    ecc_bus_pkg::dec_result_t exp_results [$];
    string                    exp_names [$];
    int                       exp_cycles [$];

    ecc_bus_pkg::dec_result_t exp_r;
    string                    exp_n;
    int                       exp_c;
    ecc_bus_pkg::dec_result_t last_result;

    `include "tb_ecc_model.svh"

    ecc_secded_top ecc_secded_top_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .enc_data  (enc_data),
        .enc_check (enc_check),
        .dec_in    (dec_in),
        .dec_valid (dec_valid),
        .bypass    (bypass),
        .dec_out   (dec_out),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("ERROR: %s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            fail_run("the run did not finish within the cycle limit");
        end
    end

    task automatic send_word(input string name, input ecc_bus_pkg::codeword_t cw,
                             input logic byp);
        @(posedge clk);
        #1;
        dec_in = cw;
        bypass = byp;
        dec_valid = 1'b1;
        exp_results.push_back(ref_decode(cw, byp));
        exp_names.push_back(name);
        exp_cycles.push_back(cycles);
    endtask

    // junk on the inputs while idle must not reach the output.
    task automatic idle_cycle();
        @(posedge clk);
        #1;
        dec_valid = 1'b0;
        dec_in.data = random_data();
        bypass = next_bit();
    endtask

    function automatic ecc_bus_pkg::codeword_t clean_word();
        ecc_bus_pkg::codeword_t cw;
        cw.data = random_data();
        cw.check = ref_encode(cw.data);
        return cw;
    endfunction

    // outputs are sampled on the falling edge, away from the register update.
    always @(negedge clk) begin
        if (arst_n) begin
            if (out_valid === 1'b1) begin
                if (exp_results.size() == 0) begin
                    fail_run("out_valid was high with no word outstanding");
                end else begin
                    exp_r = exp_results.pop_front();
                    exp_n = exp_names.pop_front();
                    exp_c = exp_cycles.pop_front();
                    check_value({exp_n, " result"}, exp_r, dec_out);
                    check_value({exp_n, " latency"}, exp_c + 1, cycles);
                    last_result = exp_r;
                    results_seen++;
                end
            end else if (out_valid === 1'b0) begin
                check_value("hold between strobes", last_result, dec_out);
            end else begin
                fail_run("out_valid is unknown after reset");
            end
        end
    end

    initial begin
        ecc_bus_pkg::codeword_t cw;
        int                     idx_a;
        int                     idx_b;
        int                     flips;

        lfsr_state = 32'h4b5f;
        cycles = 0;
        results_seen = 0;
        arst_n = 1'b0;
        enc_data = '0;
        dec_in = '0;
        dec_valid = 1'b0;
        bypass = 1'b0;
        last_result = '0;
        for (int i = 0; i < ecc_code_pkg::data_w; i++) begin
            columns[i] = column_of(i);
        end

        repeat (reset_cycles) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_value("reset valid", 1'b0, out_valid);
        check_value("reset result", '0, dec_out);

        // encode path, random words and then one walking bit per column.
        repeat (num_vectors) begin
            @(posedge clk);
            #1;
            enc_data = random_data();
            @(negedge clk);
            check_value("encode", ref_encode(enc_data), enc_check);
        end
        for (int i = 0; i < ecc_code_pkg::data_w; i++) begin
            @(posedge clk);
            #1;
            enc_data = ecc_code_pkg::data_t'(1) << i;
            @(negedge clk);
            check_value("encode walk", ref_encode(enc_data), enc_check);
        end

        repeat (num_vectors) begin
            send_word("clean", clean_word(), 1'b0);
        end

        repeat (num_vectors) begin
            cw = clean_word();
            idx_a = random_bits(7) % ecc_code_pkg::data_w;
            cw.data[idx_a] = ~cw.data[idx_a];
            send_word("single data", cw, 1'b0);
        end

        repeat (num_vectors) begin
            cw = clean_word();
            idx_a = random_bits(3);
            cw.check[idx_a] = ~cw.check[idx_a];
            send_word("single check", cw, 1'b0);
        end

        // every codeword position once, check bits included.
        for (int k = 0; k < cw_w; k++) begin
            cw = clean_word();
            cw[k] = ~cw[k];
            send_word("single sweep", cw, 1'b0);
        end

        repeat (num_vectors) begin
            cw = clean_word();
            idx_a = random_bits(7) % cw_w;
            idx_b = idx_a;
            while (idx_b == idx_a) begin
                idx_b = random_bits(7) % cw_w;
            end
            cw[idx_a] = ~cw[idx_a];
            cw[idx_b] = ~cw[idx_b];
            send_word("double", cw, 1'b0);
        end

        repeat (num_vectors) begin
            cw = clean_word();
            flips = random_bits(2);
            for (int f = 0; f < flips; f++) begin
                idx_a = random_bits(7) % cw_w;
                cw[idx_a] = ~cw[idx_a];
            end
            send_word("bypass", cw, 1'b1);
            if (next_bit()) begin
                idle_cycle();
            end
        end

        // the decode latency is one cycle, so a few cycles drain every word.
        idle_cycle();
        repeat (4) @(posedge clk);

        $display("checked %0d decode results", results_seen);
        if (exp_results.size() != 0) begin
            fail_run("some decode results never came out");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- build.f
+incdir+verification
source/ecc_code_pkg.sv
source/ecc_bus_pkg.sv
source/ecc_encoder.sv
source/ecc_syndrome_decoder.sv
source/ecc_correct_stage.sv
source/ecc_secded_top.sv
verification/tb_ecc_secded_top.sv

//--- Bender.yml
package:
  name: ecc_secded

sources:
  - source/ecc_code_pkg.sv
  - source/ecc_bus_pkg.sv
  - source/ecc_encoder.sv
  - source/ecc_syndrome_decoder.sv
  - source/ecc_correct_stage.sv
  - source/ecc_secded_top.sv

  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_ecc_secded_top.sv
